//--- Makefile
TOP := lsu_pipe_tb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -f lsu_pipe_top.f

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- lsu_pipe_top.f
source/lsu_pkg.sv
source/lsu_ex0_decode.sv
source/lsu_ex1_agen.sv
source/lsu_dmem.sv
source/lsu_ex2_result.sv
source/lsu_pipe_top.sv
tb/lsu_pipe_tb.sv

//--- source/lsu_dmem.sv
module lsu_dmem #(
  parameter int DMEM_WORDS = 64
) (
  input  logic              i_clk,
  input  lsu_pkg::mem_req_t i_req,
  output logic [63:0]       o_rd_data
);

  localparam int IDX_W = $clog2(DMEM_WORDS);

  logic [63:0]      mem [DMEM_WORDS];
  logic [63:0]      r_rd_data;
  logic [IDX_W-1:0] w_idx;

  // Upper address bits wrap onto the array
  assign w_idx = i_req.word_idx[IDX_W-1:0];

  // ------------------------------------------------------------------
  // Byte-masked write, one lane per mask bit
  // ------------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_req.write) begin
      for (int b = 0; b < 8; b++) begin
        if (i_req.mask[b]) begin
          mem[w_idx][b*8 +: 8] <= i_req.wdata[b*8 +: 8];
        end
      end
    end
  end

  // Registered read, data valid in the following cycle
  always_ff @(posedge i_clk) begin
    if (i_req.read) begin
      r_rd_data <= mem[w_idx];
    end
  end

  assign o_rd_data = r_rd_data;

endmodule

//--- source/lsu_ex0_decode.sv
module lsu_ex0_decode
  import lsu_pkg::*;
(
  input  logic   i_clk,
  input  logic   i_reset_n,
  input  issue_t i_issue,
  output issue_t o_issue,
  output ctrl_t  o_ctrl
);

  issue_t     r_issue;
  logic [6:0] w_opcode;
  logic [2:0] w_funct3;
  logic [4:0] w_funct5;

  // Issue register, start of EX0
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_issue <= '0;
    end else begin
      r_issue <= i_issue;
    end
  end

  assign w_opcode = r_issue.inst[6:0];
  assign w_funct3 = r_issue.inst[14:12];
  assign w_funct5 = r_issue.inst[31:27];

  // ------------------------------------------------------------------
  // Decode
  // ------------------------------------------------------------------
  always_comb begin
    o_ctrl      = '0;
    o_ctrl.op   = OP_NONE;
    o_ctrl.size = size_e'(w_funct3[1:0]);
    case (w_opcode)
      OPC_LOAD: begin
        o_ctrl.op   = OP_LOAD;
        o_ctrl.sign = ~w_funct3[2];  // LBU/LHU/LWU
        o_ctrl.imm  = r_issue.inst[31:20];
      end
      OPC_STORE: begin
        if (!w_funct3[2]) begin
          o_ctrl.op  = OP_STORE;
          o_ctrl.imm = {r_issue.inst[31:25], r_issue.inst[11:7]};
        end
      end
      OPC_AMO: begin
        // Only .W and .D forms exist
        if (w_funct3 == 3'b010 || w_funct3 == 3'b011) begin
          if (w_funct5 == FUNCT5_LR) begin
            o_ctrl.op = OP_LR;
          end else if (w_funct5 == FUNCT5_SC) begin
            o_ctrl.op = OP_SC;
          end
        end
      end
      default: begin
        o_ctrl.op = OP_NONE;
      end
    endcase
  end

  assign o_issue = r_issue;

endmodule

//--- source/lsu_ex1_agen.sv
module lsu_ex1_agen
  import lsu_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_reset_n,
  input  issue_t   i_issue,
  input  ctrl_t    i_ctrl,
  output mem_req_t o_mem_req,
  output ex2_t     o_ex2
);

  issue_t            r_ex1_issue;
  ctrl_t             r_ex1_ctrl;
  ex2_t              r_ex2;
  logic              r_resv_valid;
  logic [XLEN-4:0]   r_resv_word;

  logic [XLEN-1:0]   w_addr;
  logic              w_misalign;
  logic [XBYTES-1:0] w_lane_mask;
  logic              w_is_read_op;
  logic              w_is_write_op;
  logic              w_sc_ok;
  exc_e              w_exc;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_issue <= '0;
      r_ex1_ctrl  <= '0;
    end else begin
      r_ex1_issue <= i_issue;
      r_ex1_ctrl  <= i_ctrl;
    end
  end

  // ------------------------------------------------------------------
  // Address and alignment
  // ------------------------------------------------------------------
  assign w_addr = r_ex1_issue.rs1 + {{(XLEN-12){r_ex1_ctrl.imm[11]}}, r_ex1_ctrl.imm};

  always_comb begin
    case (r_ex1_ctrl.size)
      SIZE_B:  begin w_misalign = 1'b0;            w_lane_mask = XBYTES'(8'h01); end
      SIZE_H:  begin w_misalign = w_addr[0];       w_lane_mask = XBYTES'(8'h03); end
      SIZE_W:  begin w_misalign = |w_addr[1:0];    w_lane_mask = XBYTES'(8'h0f); end
      default: begin w_misalign = |w_addr[2:0];    w_lane_mask = '1;             end
    endcase
  end

  assign w_is_read_op  = (r_ex1_ctrl.op == OP_LOAD) || (r_ex1_ctrl.op == OP_LR);
  assign w_is_write_op = (r_ex1_ctrl.op == OP_STORE) || (r_ex1_ctrl.op == OP_SC);

  assign w_exc = !w_misalign    ? EXC_NONE :
                 w_is_read_op   ? EXC_LD_MISALIGN :
                 w_is_write_op  ? EXC_ST_MISALIGN : EXC_NONE;

  // SC hits only a live reservation on the same word
  assign w_sc_ok = (r_ex1_ctrl.op == OP_SC) && !w_misalign && r_resv_valid &&
                   (r_resv_word == w_addr[XLEN-1:OFS_W]);

  always_comb begin
    o_mem_req          = '0;
    o_mem_req.read     = r_ex1_issue.valid && !w_misalign && w_is_read_op;
    o_mem_req.write    = r_ex1_issue.valid && !w_misalign &&
                         ((r_ex1_ctrl.op == OP_STORE) || w_sc_ok);
    o_mem_req.word_idx = w_addr[OFS_W +: WORD_IDX_W];
    o_mem_req.mask     = w_lane_mask << w_addr[OFS_W-1:0];
    o_mem_req.wdata    = r_ex1_issue.rs2 << {w_addr[OFS_W-1:0], 3'b000};
  end

  // ------------------------------------------------------------------
  // LR/SC reservation and EX2 register
  // ------------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_resv_valid <= 1'b0;
      r_resv_word  <= '0;
      r_ex2        <= '0;
    end else begin
      if (r_ex1_issue.valid && (r_ex1_ctrl.op == OP_LR) && !w_misalign) begin
        r_resv_valid <= 1'b1;
        r_resv_word  <= w_addr[XLEN-1:OFS_W];
      end else if (r_ex1_issue.valid && (r_ex1_ctrl.op == OP_SC)) begin
        r_resv_valid <= 1'b0;  // Pass or fail
      end
      r_ex2.valid  <= r_ex1_issue.valid;
      r_ex2.op     <= r_ex1_ctrl.op;
      r_ex2.size   <= r_ex1_ctrl.size;
      r_ex2.sign   <= r_ex1_ctrl.sign;
      r_ex2.rd     <= r_ex1_issue.rd;
      r_ex2.offset <= w_addr[OFS_W-1:0];
      r_ex2.exc    <= w_exc;
      r_ex2.sc_ok  <= w_sc_ok;
    end
  end

  assign o_ex2 = r_ex2;

endmodule

//--- source/lsu_ex2_result.sv
module lsu_ex2_result
  import lsu_pkg::*;
(
  input  logic            i_clk,
  input  logic            i_reset_n,
  input  ex2_t            i_ex2,
  input  logic [XLEN-1:0] i_rd_data,
  output wb_t             o_wb
);

  logic [XLEN-1:0] w_shifted;
  logic [XLEN-1:0] w_load_data;
  logic [XLEN-1:0] w_result;
  logic            w_signed;
  logic            w_writes_rd;
  wb_t             w_wb_next;
  wb_t             r_wb;

  // ------------------------------------------------------------------
  // Lane extraction
  // ------------------------------------------------------------------
  assign w_shifted = i_rd_data >> {i_ex2.offset, 3'b000};

  // LR.W result is always sign-extended
  assign w_signed = i_ex2.sign || (i_ex2.op == OP_LR);

  always_comb begin
    case (i_ex2.size)
      SIZE_B: begin
        w_load_data = {{(XLEN-8){w_signed & w_shifted[7]}}, w_shifted[7:0]};
      end
      SIZE_H: begin
        w_load_data = {{(XLEN-16){w_signed & w_shifted[15]}}, w_shifted[15:0]};
      end
      SIZE_W: begin
        w_load_data = {{(XLEN-32){w_signed & w_shifted[31]}}, w_shifted[31:0]};
      end
      default: begin
        w_load_data = w_shifted;
      end
    endcase
  end

  // ------------------------------------------------------------------
  // Result select
  // ------------------------------------------------------------------
  always_comb begin
    w_result = '0;
    if (i_ex2.exc == EXC_NONE) begin
      case (i_ex2.op)
        OP_LOAD, OP_LR: w_result = w_load_data;
        OP_SC:          w_result = XLEN'(!i_ex2.sc_ok);  // 0 on success
        default:        w_result = '0;
      endcase
    end
  end

  assign w_writes_rd = (i_ex2.op == OP_LOAD) || (i_ex2.op == OP_LR) ||
                       (i_ex2.op == OP_SC);

  always_comb begin
    w_wb_next.valid = i_ex2.valid;
    w_wb_next.rd_we = i_ex2.valid && w_writes_rd && (i_ex2.exc == EXC_NONE) &&
                      (i_ex2.rd != '0);  // x0 is never written
    w_wb_next.rd    = i_ex2.rd;
    w_wb_next.data  = w_result;
    w_wb_next.exc   = i_ex2.exc;
  end

  // EX3 writeback register
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_wb <= '0;
    end else begin
      r_wb <= w_wb_next;
    end
  end

  assign o_wb = r_wb;

endmodule

//--- source/lsu_pipe_top.sv
module lsu_pipe_top
  import lsu_pkg::*;
#(
  parameter int DMEM_WORDS = 64
) (
  input  logic   i_clk,
  input  logic   i_reset_n,
  input  issue_t i_issue,
  output wb_t    o_wb
);

  issue_t          r_ex0_issue;
  ctrl_t           ex0_ctrl;
  mem_req_t        mem_req;
  ex2_t            ex2;
  logic [XLEN-1:0] rd_data;

  // ------------------------------------------------------------------
  // EX0 issue register and decode
  // ------------------------------------------------------------------
  lsu_ex0_decode u_ex0_decode (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_issue   (i_issue),
    .o_issue   (r_ex0_issue),
    .o_ctrl    (ex0_ctrl)
  );

  // EX1 address, memory request, reservation
  lsu_ex1_agen u_ex1_agen (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_issue   (r_ex0_issue),
    .i_ctrl    (ex0_ctrl),
    .o_mem_req (mem_req),
    .o_ex2     (ex2)
  );

  lsu_dmem #(
    .DMEM_WORDS (DMEM_WORDS)
  ) u_dmem (
    .i_clk     (i_clk),
    .i_req     (mem_req),
    .o_rd_data (rd_data)
  );

  // EX2 data alignment, EX3 writeback
  lsu_ex2_result u_ex2_result (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_ex2     (ex2),
    .i_rd_data (rd_data),
    .o_wb      (o_wb)
  );

endmodule

//--- source/lsu_pkg.sv
package lsu_pkg;

  // ------------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------------
  localparam int XLEN       = 64;
  localparam int XBYTES     = XLEN / 8;
  localparam int OFS_W      = $clog2(XBYTES);  // Byte offset within a word
  localparam int RD_W       = 5;
  localparam int WORD_IDX_W = 32;

  // RISC-V major opcodes handled by the pipe
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;
  localparam logic [6:0] OPC_AMO   = 7'b0101111;

  localparam logic [4:0] FUNCT5_LR = 5'b00010;
  localparam logic [4:0] FUNCT5_SC = 5'b00011;

  // ------------------------------------------------------------------
  // Encodings
  // ------------------------------------------------------------------
  typedef enum logic [2:0] {OP_NONE, OP_LOAD, OP_STORE, OP_LR, OP_SC} lsu_op_e;

  // log2 of the access width in bytes
  typedef enum logic [1:0] {SIZE_B, SIZE_H, SIZE_W, SIZE_DW} size_e;

  typedef enum logic [1:0] {EXC_NONE, EXC_LD_MISALIGN, EXC_ST_MISALIGN} exc_e;

  // ------------------------------------------------------------------
  // Pipe payloads
  // ------------------------------------------------------------------
  typedef struct packed {
    logic            valid;
    logic [31:0]     inst;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic [RD_W-1:0] rd;
  } issue_t;

  typedef struct packed {
    lsu_op_e     op;
    size_e       size;
    logic        sign;  // 1: sign-extend load data
    logic [11:0] imm;
  } ctrl_t;

  typedef struct packed {
    logic                  read;
    logic                  write;
    logic [WORD_IDX_W-1:0] word_idx;
    logic [XBYTES-1:0]     mask;
    logic [XLEN-1:0]       wdata;
  } mem_req_t;

  typedef struct packed {
    logic             valid;
    lsu_op_e          op;
    size_e            size;
    logic             sign;
    logic [RD_W-1:0]  rd;
    logic [OFS_W-1:0] offset;
    exc_e             exc;
    logic             sc_ok;
  } ex2_t;

  typedef struct packed {
    logic            valid;
    logic            rd_we;
    logic [RD_W-1:0] rd;
    logic [XLEN-1:0] data;
    exc_e            exc;
  } wb_t;

endpackage

//--- tb/lsu_pipe_tb.sv
module lsu_pipe_tb
  import lsu_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int          MAX_TESTS = 128;
  localparam int          COLS      = 7;  // inst rs1 rs2 rd rd_we data exc
  localparam int          LATENCY   = 3;  // Sampling edge to writeback edge
  localparam logic [31:0] SEED      = 32'h9a5c1de3;

  typedef struct packed {
    logic [RD_W-1:0] rd;
    logic            rd_we;
    logic [XLEN-1:0] data;
    exc_e            exc;
    int              issue_edge;
  } expect_t;

  logic        clk;
  logic        reset_n;
  issue_t      issue;
  wb_t         wb;

  logic [63:0] test_mem [MAX_TESTS*COLS];
  expect_t     exp_q [$];
  int          n_tests     = 0;
  int          done_count  = 0;
  int          pass_count  = 0;
  int          fail_count  = 0;
  int          stray_count = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;
  logic        limit_set   = 1'b0;

  lsu_pipe_top #(
    .DMEM_WORDS (64)
  ) dut_i (
    .i_clk     (clk),
    .i_reset_n (reset_n),
    .i_issue   (issue),
    .o_wb      (wb)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------
  task automatic compare_value(input int test_no, input string field,
                               input logic [63:0] actual, input logic [63:0] expected,
                               inout logic ok);
    if (actual !== expected) begin
      $display("Error: %0d ns test %0d %s is %h, expected %h",
               $time, test_no, field, actual, expected);
      ok = 1'b0;
    end
  endtask

  // Unused rows keep a fill with all-ones upper bits that ends the list
  task automatic load_tests();
    foreach (test_mem[i]) begin
      test_mem[i] = {32'hffff_ffff, 32'(i)};
    end
    $readmemh("tb/lsu_tests.txt", test_mem);
    while (n_tests < MAX_TESTS && test_mem[n_tests*COLS][63:32] != 32'hffff_ffff) begin
      n_tests++;
    end
    if (n_tests == 0) begin
      $display("No tests found in tb/lsu_tests.txt");
    end
  endtask

  task automatic drive_test(input int t);
    int      base;
    expect_t exp;
    base = t * COLS;
    @(negedge clk);
    issue.valid    = 1'b1;
    issue.inst     = test_mem[base][31:0];
    issue.rs1      = test_mem[base+1];
    issue.rs2      = test_mem[base+2];
    issue.rd       = test_mem[base+3][RD_W-1:0];
    exp.rd         = test_mem[base+3][RD_W-1:0];
    exp.rd_we      = test_mem[base+4][0];
    exp.data       = test_mem[base+5];
    exp.exc        = exc_e'(test_mem[base+6][1:0]);
    exp.issue_edge = cycle_count + 1;  // Taken at the next rising edge
    exp_q.push_back(exp);
  endtask

  // ------------------------------------------------------------------
  // Writeback monitor sampled mid-cycle
  // ------------------------------------------------------------------
  always @(negedge clk) begin : check_wb
    expect_t exp;
    logic    ok;
    if (reset_n && wb.valid) begin
      if (exp_q.size() == 0) begin
        $display("Unexpected writeback at %0d ns for rd %0d with no access outstanding",
                 $time, wb.rd);
        stray_count++;
      end else begin
        exp = exp_q.pop_front();
        ok  = 1'b1;
        compare_value(done_count + 1, "rd", 64'(wb.rd), 64'(exp.rd), ok);
        compare_value(done_count + 1, "rd_we", 64'(wb.rd_we), 64'(exp.rd_we), ok);
        compare_value(done_count + 1, "data", wb.data, exp.data, ok);
        compare_value(done_count + 1, "exc", 64'(wb.exc), 64'(exp.exc), ok);
        compare_value(done_count + 1, "latency", 64'(cycle_count - exp.issue_edge),
                      64'(LATENCY), ok);
        if (ok) begin
          pass_count++;
        end else begin
          fail_count++;
        end
        $display("test %0d %s", done_count + 1, ok ? "ok" : "FAILED");
        done_count++;
      end
    end
  end

  // Cycle limit scales with the number of tests
  initial begin : watchdog
    wait (limit_set);
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, only %0d of %0d results came back",
             cycle_count, done_count, n_tests);
    $display("sim failed");
    $finish;
  end

  // ------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------
  initial begin : stimulus
    int gap;
    void'($urandom(SEED));
    reset_n = 1'b0;
    issue   = '0;
    load_tests();
    cycle_limit = 3 * n_tests + 20;
    limit_set   = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;

    for (int t = 0; t < n_tests; t++) begin
      drive_test(t);
      gap = $urandom_range(2, 0);  // 0 gives back to back
      repeat (gap) begin
        @(negedge clk);
        issue = '0;
      end
    end
    @(negedge clk);
    issue = '0;

    wait (done_count == n_tests);
    repeat (4) @(negedge clk);  // Catch stray writebacks
    $display("%0d tests, %0d passed, %0d failed, %0d unexpected writebacks",
             n_tests, pass_count, fail_count, stray_count);
    if (fail_count == 0 && stray_count == 0 && n_tests > 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- tb/lsu_tests.txt
// Columns (hex): inst rs1 rs2 rd expected_rd_we expected_data expected_exc
// exc: 0 none, 1 load misaligned, 2 store misaligned
00003023 100 8877665544332211 0 0 0 0
00003003 100 0 05 1 8877665544332211 0
00002003 104 0 06 1 ffffffff88776655 0
00006003 104 0 07 1 0000000088776655 0
00001003 102 0 08 1 0000000000004433 0
00005003 106 0 09 1 0000000000008877 0
00001003 106 0 0a 1 ffffffffffff8877 0
00000003 107 0 0b 1 ffffffffffffff88 0
00004003 107 0 0c 1 0000000000000088 0
00002023 100 11111111cafef00d 0 0 0 0
00003003 100 0 0d 1 88776655cafef00d 0
00001023 104 000000000000a5b6 0 0 0 0
00000023 107 000000000000007f 0 0 0 0
00003003 100 0 0e 1 7f77a5b6cafef00d 0
00002003 104 0 0f 1 000000007f77a5b6 0
00000003 103 0 11 1 ffffffffffffffca 0
00004003 102 0 12 1 00000000000000fe 0
ff803003 108 0 13 1 7f77a5b6cafef00d 0
00003423 100 0123456789abcdef 0 0 0 0
00c02003 100 0 14 1 0000000001234567 0
00002003 102 0 15 0 0 1
00003003 104 0 16 0 0 1
00001003 101 0 17 0 0 1
00003023 104 ffffffffffffffff 0 0 0 2
00002023 10a ffffffffffffffff 0 0 0 2
00001023 103 ffffffffffffffff 0 0 0 2
00003003 100 0 18 1 7f77a5b6cafef00d 0
00003003 108 0 19 1 0123456789abcdef 0
00003023 110 0000000080000001 0 0 0 0
1000202f 110 0 1a 1 ffffffff80000001 0
1800202f 110 0000000012345678 1b 1 0 0
00003003 110 0 1c 1 0000000012345678 0
1800202f 110 00000000aaaaaaaa 1d 1 1 0
00003003 110 0 1e 1 0000000012345678 0
1000302f 110 0 1f 1 0000000012345678 0
1800302f 118 0000000000005555 01 1 1 0
1800302f 110 0000000000005555 02 1 1 0
1800202f 112 0 03 0 0 2
00003003 110 0 00 0 0000000012345678 0
00000013 100 0 04 0 0 0
00000023 118 000000000000009c 0 0 0 0
00000003 118 0 05 1 ffffffffffffff9c 0
